// File: rtl/fm_bus_pkg.sv
`default_nettype none
//------------------------------
// CPU side of the FM timer core.
// Bus cycle struct, register numbers
// and the status byte layout. Files
// reach these by fm_bus_pkg::name.
//------------------------------

package fm_bus_pkg;

    typedef logic [7:0] bus_data_t;  // Data bus word and register contents

    // One CPU bus cycle, sampled on clk
    typedef struct packed {
        logic [1:0] addr;   // Bit 0 picks address or data, bit 1 selects part II
        bus_data_t  din;
        logic       cs_n;
        logic       wr_n;
    } cpu_bus_t;

    localparam bus_data_t REG_TIMER_A_HI = 8'h24;  // Timer A bits 9..2
    localparam bus_data_t REG_TIMER_A_LO = 8'h25;  // Timer A bits 1..0
    localparam bus_data_t REG_TIMER_B    = 8'h26;
    localparam bus_data_t REG_TIMER_CTL  = 8'h27;  // Load, enable and flag reset bits

    // Status byte
    localparam int STATUS_BUSY_BIT   = 7;
    localparam int STATUS_FLAG_B_BIT = 1;
    localparam int STATUS_FLAG_A_BIT = 0;

    localparam int BUSY_TICKS = 32;  // cen cycles of busy per data write

endpackage

`default_nettype wire

// File: rtl/fm_prescaler.sv
`timescale 1ns/10ps
`default_nettype none
//------------------------------
// Timer prescaler. Counts cen cycles
// and gives one tick every TICK_DIV
// of them, a single clk wide.
//------------------------------

module fm_prescaler (
    input  logic clk,
    input  logic arst_n,
    input  logic cen,
    output logic tick
);

    localparam int DIV_W = $clog2(fm_timer_pkg::TICK_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             last;

    assign last = (div_cnt == DIV_W'(fm_timer_pkg::TICK_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (cen) begin
            div_cnt <= last ? '0 : div_cnt + 1'b1;  // Wraps at TICK_DIV
        end
    end

    assign tick = cen & last;

    // Downstream timers rely on tick lining up with cen
    a_tick_on_cen: assert property (
        @(posedge clk) disable iff (!arst_n)
        tick |-> cen
    );

endmodule

`default_nettype wire

// File: rtl/fm_regs.sv
`timescale 1ns/10ps
`default_nettype none
//------------------------------
// CPU register block of the timer core.
// Address writes latch a register number,
// data writes update timer values and
// control. Also keeps the busy counter,
// drives the status byte and irq_n.
//------------------------------

module fm_regs (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     cen,
    input  fm_bus_pkg::cpu_bus_t     bus,
    input  logic                     flag_a,
    input  logic                     flag_b,
    output fm_timer_pkg::timer_ctl_t ctl_a,
    output fm_timer_pkg::timer_ctl_t ctl_b,
    output fm_timer_pkg::timer_a_val_t val_a,
    output fm_timer_pkg::timer_b_val_t val_b,
    output fm_bus_pkg::bus_data_t    dout,
    output logic                     irq_n
);

    localparam int BUSY_W = $clog2(fm_bus_pkg::BUSY_TICKS + 1);

    logic                  write;
    logic                  addr_wr;
    logic                  data_wr;
    fm_bus_pkg::bus_data_t reg_sel;   // Latched register number
    logic [BUSY_W-1:0]     busy_cnt;
    logic                  busy;

    assign write   = ~bus.cs_n & ~bus.wr_n;
    assign addr_wr = write && (bus.addr == 2'b00);
    assign data_wr = write && (bus.addr == 2'b01);  // Part II never matches

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_sel <= '0;
        end else if (addr_wr) begin
            reg_sel <= bus.din;
        end
    end

    // Timer reload values
    always_ff @(posedge clk) begin
        if (data_wr) begin
            case (reg_sel)
                fm_bus_pkg::REG_TIMER_A_HI: val_a[fm_timer_pkg::TIMER_A_W-1:2] <= bus.din;
                fm_bus_pkg::REG_TIMER_A_LO: val_a[1:0] <= bus.din[1:0];
                fm_bus_pkg::REG_TIMER_B:    val_b <= bus.din;
                default: ;
            endcase
        end
    end

    // Flag resets from the control register last one clk
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctl_a <= '0;
            ctl_b <= '0;
        end else begin
            ctl_a.clr_flag <= 1'b0;
            ctl_b.clr_flag <= 1'b0;
            if (data_wr && (reg_sel == fm_bus_pkg::REG_TIMER_CTL)) begin
                ctl_a.load     <= bus.din[0];
                ctl_b.load     <= bus.din[1];
                ctl_a.irq_en   <= bus.din[2];
                ctl_b.irq_en   <= bus.din[3];
                ctl_a.clr_flag <= bus.din[4];
                ctl_b.clr_flag <= bus.din[5];
            end
        end
    end

    // Busy only reports and never holds off a write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(fm_bus_pkg::BUSY_TICKS);  // Restarts on every data write
        end else if (cen && busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

    // Status is visible on every address
    always_comb begin
        dout = '0;
        dout[fm_bus_pkg::STATUS_BUSY_BIT]   = busy;
        dout[fm_bus_pkg::STATUS_FLAG_B_BIT] = flag_b;
        dout[fm_bus_pkg::STATUS_FLAG_A_BIT] = flag_a;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_n <= 1'b1;
        end else begin
            irq_n <= ~(flag_a | flag_b);  // One clk behind the flags
        end
    end

    a_busy_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        busy_cnt <= BUSY_W'(fm_bus_pkg::BUSY_TICKS)
    );

endmodule

`default_nettype wire

// File: rtl/fm_timer.sv
`timescale 1ns/10ps
`default_nettype none
//------------------------------
// Count-up interval timer. Starts from
// value when load rises, steps every
// SUBDIV ticks and reloads on overflow.
// Shared by timer A and timer B through
// the count_t type parameter.
//------------------------------

module fm_timer #(
    parameter type count_t = logic [7:0],
    parameter int  SUBDIV  = 1
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     tick,
    input  fm_timer_pkg::timer_ctl_t ctl,
    input  count_t                   value,
    output logic                     flag
);

    localparam int SUB_W = (SUBDIV > 1) ? $clog2(SUBDIV) : 1;

    logic             load_l;
    logic             load_rise;
    logic [SUB_W-1:0] sub_cnt;
    logic             sub_last;
    logic             step;
    logic             overflow;
    count_t           cnt;

    assign load_rise = ctl.load & ~load_l;
    assign sub_last  = (sub_cnt == SUB_W'(SUBDIV - 1));
    assign step      = tick && ctl.load && sub_last;
    assign overflow  = step && !load_rise && (cnt == '1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_l  <= 1'b0;
            sub_cnt <= '0;
            cnt     <= '0;
        end else begin
            load_l <= ctl.load;
            if (load_rise) begin
                cnt     <= value;
                sub_cnt <= '0;
            end else if (ctl.load && tick) begin
                sub_cnt <= sub_last ? '0 : sub_cnt + 1'b1;
                if (step) begin
                    cnt <= overflow ? value : count_t'(cnt + 1'b1);
                end
            end
        end
    end

    // Clear has priority over a same-edge overflow
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= 1'b0;
        end else if (ctl.clr_flag) begin
            flag <= 1'b0;
        end else if (overflow && ctl.irq_en) begin
            flag <= 1'b1;
        end
    end

    a_flag_needs_en: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(flag) |-> $past(ctl.irq_en)
    );

endmodule

`default_nettype wire

// File: rtl/fm_timer_pkg.sv
`default_nettype none
//------------------------------
// Timer side of the FM timer core.
// Counter widths, prescale ratios
// and the control bundle sent from
// the register block to each timer.
//------------------------------

package fm_timer_pkg;

    localparam int TIMER_A_W = 10;
    localparam int TIMER_B_W = 8;

    typedef logic [TIMER_A_W-1:0] timer_a_val_t;
    typedef logic [TIMER_B_W-1:0] timer_b_val_t;

    // cen cycles per prescaler tick
    localparam int TICK_DIV = 24;

    // Timer B moves once every this many ticks
    localparam int TIMER_B_SUBDIV = 16;

    // Control for one timer
    typedef struct packed {
        logic load;      // Level signal whose rising edge starts the counter
        logic irq_en;    // Overflow may set the flag
        logic clr_flag;  // Single clk pulse
    } timer_ctl_t;

endpackage

`default_nettype wire

// File: rtl/fm_timer_top.sv
`timescale 1ns/10ps
`default_nettype none
//------------------------------
// Control core of the FM sound chip.
// CPU register bus in, status byte and
// irq_n out. Holds the register block,
// the prescaler and timers A and B.
//------------------------------

module fm_timer_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cen,      // External clock enable
    input  fm_bus_pkg::cpu_bus_t  bus,
    output fm_bus_pkg::bus_data_t dout,
    output logic                  irq_n
);

    fm_timer_pkg::timer_ctl_t   ctl_a;
    fm_timer_pkg::timer_ctl_t   ctl_b;
    fm_timer_pkg::timer_a_val_t val_a;
    fm_timer_pkg::timer_b_val_t val_b;
    logic                       flag_a;
    logic                       flag_b;
    logic                       tick;

    fm_regs u_regs (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cen    ( cen    ),
        .bus    ( bus    ),
        .flag_a ( flag_a ),
        .flag_b ( flag_b ),
        .ctl_a  ( ctl_a  ),
        .ctl_b  ( ctl_b  ),
        .val_a  ( val_a  ),
        .val_b  ( val_b  ),
        .dout   ( dout   ),
        .irq_n  ( irq_n  )
    );

    fm_prescaler u_prescaler (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cen    ( cen    ),
        .tick   ( tick   )
    );

    // Timer A steps on every tick
    fm_timer #(
        .count_t ( fm_timer_pkg::timer_a_val_t ),
        .SUBDIV  ( 1                           )
    ) u_timer_a (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .tick   ( tick   ),
        .ctl    ( ctl_a  ),
        .value  ( val_a  ),
        .flag   ( flag_a )
    );

    fm_timer #(
        .count_t ( fm_timer_pkg::timer_b_val_t  ),
        .SUBDIV  ( fm_timer_pkg::TIMER_B_SUBDIV )  // 16 times slower than A
    ) u_timer_b (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .tick   ( tick   ),
        .ctl    ( ctl_b  ),
        .value  ( val_b  ),
        .flag   ( flag_b )
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the FM timer core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fm_timer_top \
    -f tb.f \
    -o sim_fm_timer

./obj_dir/sim_fm_timer | tee sim.log

if grep -qx 'TEST RESULT: PASS' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tb.f
rtl/fm_bus_pkg.sv
rtl/fm_timer_pkg.sv
rtl/fm_prescaler.sv
rtl/fm_timer.sv
rtl/fm_regs.sv
rtl/fm_timer_top.sv
verif/tb_fm_timer_top.sv

// File: verif/tb_fm_timer_top.sv
`timescale 1ns/10ps
`default_nettype none
//------------------------------
// Directed testbench for the FM timer core.
// Drives the CPU bus, polls the status
// byte and checks flag timing and irq_n.
//------------------------------

module tb_fm_timer_top;

    localparam int CLK_PERIOD = 100;
    localparam int A_MIN      = 1000;  // Random timer values start here
    localparam int B_MIN      = 240;
    localparam int TICKS_A    = (1 << fm_timer_pkg::TIMER_A_W) - A_MIN;
    localparam int TICKS_B    = ((1 << fm_timer_pkg::TIMER_B_W) - B_MIN)
                                * fm_timer_pkg::TIMER_B_SUBDIV;
    localparam int WORST_A    = (TICKS_A + 1) * fm_timer_pkg::TICK_DIV + 3;
    localparam int WORST_B    = (TICKS_B + 1) * fm_timer_pkg::TICK_DIV + 3;
    // Two A runs, one B run, two B periods idle, plus bus and busy time
    localparam int WATCHDOG_CYCLES = (2 * WORST_A + 3 * WORST_B + 400) * 12 / 10;

    logic                  clk;
    logic                  arst_n;
    logic                  cen;
    fm_bus_pkg::cpu_bus_t  bus;
    fm_bus_pkg::bus_data_t dout;
    logic                  irq_n;
    int                    checks;
    int                    value_errors;
    int                    other_errors;

    fm_timer_top u_fm_timer_top (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cen    ( cen    ),
        .bus    ( bus    ),
        .dout   ( dout   ),
        .irq_n  ( irq_n  )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Prescaler phase is unknown, so the first step lands 1 to TICK_DIV cycles in
    function automatic int window_lo(input int ticks);
        return (ticks - 1) * fm_timer_pkg::TICK_DIV + 1;
    endfunction

    function automatic int window_hi(input int ticks);
        return ticks * fm_timer_pkg::TICK_DIV + 3;
    endfunction

    task automatic check_status(input fm_bus_pkg::bus_data_t got,
                                input fm_bus_pkg::bus_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t ns: dout is 0x%02h, expected 0x%02h (%s)",
                     $time, got, exp, what);
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t ns: irq_n is %b, expected %b (%s)", $time, got, exp, what);
        end
    endtask

    task automatic bus_write(input logic [1:0] addr, input fm_bus_pkg::bus_data_t data);
        @(posedge clk);
        #1;
        bus.addr = addr;
        bus.din  = data;
        bus.cs_n = 1'b0;
        bus.wr_n = 1'b0;
        @(posedge clk);  // Write sampled here
        #1;
        bus.cs_n = 1'b1;
        bus.wr_n = 1'b1;
    endtask

    task automatic reg_write(input fm_bus_pkg::bus_data_t num, input fm_bus_pkg::bus_data_t data);
        bus_write(2'b00, num);
        bus_write(2'b01, data);
    endtask

    task automatic status_read(output fm_bus_pkg::bus_data_t data);
        @(posedge clk);
        #1;
        data = dout;
    endtask

    task automatic set_timer_a(input fm_timer_pkg::timer_a_val_t va);
        reg_write(fm_bus_pkg::REG_TIMER_A_HI, va[9:2]);
        reg_write(fm_bus_pkg::REG_TIMER_A_LO, {6'b0, va[1:0]});
    endtask

    task automatic wait_not_busy(input int limit);
        fm_bus_pkg::bus_data_t st;
        int                    n;
        st = dout;
        n  = 0;
        while (st[fm_bus_pkg::STATUS_BUSY_BIT] && n < limit) begin
            status_read(st);
            n++;
        end
        if (st[fm_bus_pkg::STATUS_BUSY_BIT]) begin
            other_errors++;
            $display("Busy flag still set %0d cycles after the last data write", limit);
        end
    endtask

    // Counts cycles from the control write until the flag shows up
    task automatic wait_flag(input int bit_idx, input int lo, input int hi, input string what);
        fm_bus_pkg::bus_data_t st;
        int                    n;
        st = '0;
        n  = 0;
        while (!st[bit_idx] && n <= hi + 8) begin
            status_read(st);
            n++;
        end
        if (!st[bit_idx]) begin
            other_errors++;
            $display("Flag never rose within %0d cycles (%s)", n, what);
        end else if (n < lo || n > hi) begin
            other_errors++;
            $display("Flag rose after %0d cycles, outside %0d..%0d (%s)", n, lo, hi, what);
        end
    endtask

    task automatic run_timer_a(input fm_timer_pkg::timer_a_val_t va, input string what);
        fm_bus_pkg::bus_data_t st;
        int                    ticks;
        ticks = (1 << fm_timer_pkg::TIMER_A_W) - int'(va);
        reg_write(fm_bus_pkg::REG_TIMER_CTL, 8'h05);  // Load A, enable A
        wait_flag(fm_bus_pkg::STATUS_FLAG_A_BIT, window_lo(ticks), window_hi(ticks), what);
        check_status(dout, 8'h01, what);
        check_irq(irq_n, 1'b1, what);  // Still one cycle behind
        status_read(st);
        check_irq(irq_n, 1'b0, what);
        reg_write(fm_bus_pkg::REG_TIMER_CTL, 8'h10);  // Reset flag A, stop A
        repeat (2) status_read(st);
        check_status(st, 8'h80, what);
        check_irq(irq_n, 1'b1, what);
        wait_not_busy(fm_bus_pkg::BUSY_TICKS + 2);
    endtask

    task automatic test_reset_state();
        check_status(dout, 8'h00, "after reset");
        check_irq(irq_n, 1'b1, "after reset");
    endtask

    task automatic test_busy();
        fm_bus_pkg::bus_data_t st;
        reg_write(fm_bus_pkg::REG_TIMER_B, 8'h00);
        check_status(dout, 8'h80, "busy after data write");
        repeat (10) status_read(st);
        check_status(st, 8'h80, "busy 10 cycles later");
        wait_not_busy(fm_bus_pkg::BUSY_TICKS + 2 - 10);
        check_status(dout, 8'h00, "busy cleared");
    endtask

    task automatic test_timer_b(input fm_timer_pkg::timer_b_val_t vb);
        fm_bus_pkg::bus_data_t st;
        int                    ticks;
        ticks = ((1 << fm_timer_pkg::TIMER_B_W) - int'(vb)) * fm_timer_pkg::TIMER_B_SUBDIV;
        reg_write(fm_bus_pkg::REG_TIMER_B, vb);
        reg_write(fm_bus_pkg::REG_TIMER_CTL, 8'h0A);  // Load B, enable B
        wait_flag(fm_bus_pkg::STATUS_FLAG_B_BIT, window_lo(ticks), window_hi(ticks), "timer B");
        check_status(dout, 8'h02, "timer B, flag A clear");
        status_read(st);
        check_irq(irq_n, 1'b0, "timer B");
        reg_write(fm_bus_pkg::REG_TIMER_CTL, 8'h20);
        repeat (2) status_read(st);
        check_status(st, 8'h80, "flag B reset");
        check_irq(irq_n, 1'b1, "flag B reset");
        wait_not_busy(fm_bus_pkg::BUSY_TICKS + 2);
    endtask

    task automatic test_no_enable(input fm_timer_pkg::timer_a_val_t va,
                                  input fm_timer_pkg::timer_b_val_t vb);
        fm_bus_pkg::bus_data_t st;
        int                    limit_a;
        int                    limit_b;
        int                    limit;
        int                    n;
        bit                    risen;
        limit_a = window_hi((1 << fm_timer_pkg::TIMER_A_W) - int'(va));
        limit_b = window_hi(((1 << fm_timer_pkg::TIMER_B_W) - int'(vb))
                            * fm_timer_pkg::TIMER_B_SUBDIV);
        limit   = 2 * ((limit_a > limit_b) ? limit_a : limit_b);  // Two periods of the slower one
        risen   = 1'b0;
        set_timer_a(va);
        reg_write(fm_bus_pkg::REG_TIMER_B, vb);
        reg_write(fm_bus_pkg::REG_TIMER_CTL, 8'h03);  // Both loaded, no enables
        for (n = 0; n < limit && !risen; n++) begin
            status_read(st);
            risen = (st[1:0] != 2'b00);
        end
        if (risen) begin
            other_errors++;
            $display("A timer flag rose at %0t ns with its enable clear", $time);
        end
        check_irq(irq_n, 1'b1, "no enable");
        reg_write(fm_bus_pkg::REG_TIMER_CTL, 8'h00);
        wait_not_busy(fm_bus_pkg::BUSY_TICKS + 2);
    endtask

    task automatic test_ignored_writes(input fm_timer_pkg::timer_a_val_t va);
        set_timer_a(va);
        bus_write(2'b10, fm_bus_pkg::REG_TIMER_A_HI);  // Part II address write is dropped
        bus_write(2'b11, 8'h00);
        bus_write(2'b10, fm_bus_pkg::REG_TIMER_CTL);
        bus_write(2'b11, 8'h3F);
        reg_write(8'h28, 8'hFF);  // No timer register here
        wait_not_busy(fm_bus_pkg::BUSY_TICKS + 2);
        check_status(dout, 8'h00, "after ignored writes");
        run_timer_a(va, "timer A after ignored writes");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        fm_timer_pkg::timer_a_val_t va;
        fm_timer_pkg::timer_b_val_t vb;
        void'($urandom(78199));
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        clk          = 1'b0;
        arst_n       = 1'b0;
        cen          = 1'b1;
        bus          = '{addr: 2'b00, din: 8'h00, cs_n: 1'b1, wr_n: 1'b1};
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset_state();
        test_busy();
        va = fm_timer_pkg::timer_a_val_t'(A_MIN + ($urandom % 16));
        set_timer_a(va);
        run_timer_a(va, "timer A");
        vb = fm_timer_pkg::timer_b_val_t'(B_MIN + ($urandom % 16));
        test_timer_b(vb);
        test_no_enable(va, vb);
        va = fm_timer_pkg::timer_a_val_t'(A_MIN + ($urandom % 16));
        test_ignored_writes(va);

        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
